//--- project.f
+incdir+.
rx_pkg.sv
rx_beat_if.sv
rx_channel_arbiter.sv
rx_beat_fifo.sv
l2_write_formatter.sv
udma_rx_top.sv
tb_clk_gen.sv
tb_udma_rx.sv

//--- tb_udma_rx.sv
//////////////////////////////////////////////////
// random beats on all receive channels and random l2 grants
// address bits 15:14 tag the channel and bit 13 stays low,
// so the second write of a split never reaches the tag
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rx_consts.svh"

module tb_udma_rx
    import rx_pkg::*;
();

    localparam int N_CH       = `RX_N_CHANNELS;
    localparam int N_BEATS    = 40;
    localparam int N_TOTAL    = N_CH * N_BEATS;
    localparam int MAX_CYCLES = 20 * N_TOTAL;
    localparam int N_BURST    = 10;  // first beats offered back to back

    typedef struct packed
    {
        logic [7:0] ch;
        logic       split_first;
        l2_addr_t   addr;
        byte_en_t   be;
        ch_data_t   data;
    } exp_wr_t;

    logic                  clk;
    logic                  rstn;
    ch_mask_t              ch_valid;
    ch_data_t  [N_CH-1:0]  ch_data;
    ch_addr_t  [N_CH-1:0]  ch_addr;
    datasize_t [N_CH-1:0]  ch_size;
    dest_t     [N_CH-1:0]  ch_dest;
    ch_mask_t              ch_ready;
    logic                  l2_req;
    logic                  l2_gnt;
    l2_addr_t              l2_addr;
    byte_en_t              l2_be;
    ch_data_t              l2_wdata;

    integer   seed = 32'hadd19493;
    int       error_cnt;
    int       cycle_cnt;
    int       write_cnt;
    int       accept_cnt [N_CH];
    int       gen_cnt    [N_CH];
    logic     have_beat  [N_CH];
    logic     started;
    exp_wr_t  exp_q [$];   // expected writes in arrival order

    logic     prev_req;
    logic     prev_gnt;
    l2_addr_t prev_addr;
    byte_en_t prev_be;
    ch_data_t prev_data;
    logic     expect_second;

    tb_clk_gen #(
        .PERIOD_NS  ( 100 ),
        .RST_CYCLES ( 2   )
    ) tb_clk_gen_i
    (
        .clk_o  ( clk  ),
        .rstn_o ( rstn )
    );

    udma_rx_top udma_rx_top_i
    (
        .clk_i      ( clk      ),
        .rstn_i     ( rstn     ),
        .ch_valid_i ( ch_valid ),
        .ch_data_i  ( ch_data  ),
        .ch_addr_i  ( ch_addr  ),
        .ch_size_i  ( ch_size  ),
        .ch_dest_i  ( ch_dest  ),
        .ch_ready_o ( ch_ready ),
        .l2_req_o   ( l2_req   ),
        .l2_gnt_i   ( l2_gnt   ),
        .l2_addr_o  ( l2_addr  ),
        .l2_be_o    ( l2_be    ),
        .l2_wdata_o ( l2_wdata )
    );

    //////////////////////////////////////////////////
    // reference model

    function automatic l2_addr_t region_base(input dest_t dest);
        case (dest)
            2'd0:    return {`RX_REGION_L2, 24'h0};
            2'd1:    return {`RX_REGION_PERIPH, 20'h0};
            2'd2:    return {`RX_REGION_L1, 24'h0};
            default: return {`RX_REGION_ACCEL, 24'h0};
        endcase
    endfunction

    // one write per touched word with bytes walking up from the offset
    function automatic void push_expected(input int c, input ch_addr_t addr,
                                          input datasize_t size, input dest_t dest,
                                          input ch_data_t data);
        exp_wr_t lo;
        exp_wr_t hi;
        int      lane;
        lo         = '0;
        hi         = '0;
        lo.ch      = 8'(c);
        hi.ch      = 8'(c);
        lo.addr    = region_base(dest) | {16'h0, addr[15:2], 2'b00};
        hi.addr    = region_base(dest) | {16'h0, addr[15:2] + 14'd1, 2'b00};
        for (int i = 0; i < (1 << size); i++)
        begin
            lane = int'(addr[1:0]) + i;
            if (lane < 4)
            begin
                lo.be[lane]           = 1'b1;
                lo.data[8*lane +: 8]  = data[8*i +: 8];
            end
            else
            begin
                hi.be[lane-4]          = 1'b1;
                hi.data[8*(lane-4) +: 8] = data[8*i +: 8];
            end
        end
        lo.split_first = (hi.be != '0);
        exp_q.push_back(lo);
        if (hi.be != '0)
            exp_q.push_back(hi);
    endfunction

    function automatic logic all_done();
        int sum;
        sum = 0;
        for (int c = 0; c < N_CH; c++)
            sum += accept_cnt[c];
        return (sum == N_TOTAL) && (exp_q.size() == 0);
    endfunction

    // match a granted write against the oldest pending one of its channel
    task automatic check_write();
        int      idx;
        exp_wr_t want;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++)
            if (idx < 0 && exp_q[i].ch == 8'(l2_addr[15:14]))
                idx = i;
        assert (idx >= 0) else
        begin
            $display("unexpected l2 write at %0t to %h with no beat pending", $time, l2_addr);
            error_cnt++;
        end
        if (idx >= 0)
        begin
            want = exp_q[idx];
            exp_q.delete(idx);
            assert (l2_addr == want.addr) else
            begin
                $display("[ERROR] %0t l2_addr_o expected %h got %h", $time, want.addr, l2_addr);
                error_cnt++;
            end
            assert (l2_be == want.be) else
            begin
                $display("[ERROR] %0t l2_be_o expected %b got %b", $time, want.be, l2_be);
                error_cnt++;
            end
            assert (l2_wdata == want.data) else
            begin
                $display("[ERROR] %0t l2_wdata_o expected %h got %h", $time, want.data, l2_wdata);
                error_cnt++;
            end
            write_cnt++;
            expect_second = want.split_first;
        end
    endtask

    task automatic new_beat(input int c);
        int r;
        r          = $random(seed);
        ch_data[c] = $random(seed);
        ch_addr[c] = {c[1:0], 1'b0, r[12:0]};  // channel tag on top
        ch_size[c] = datasize_t'($unsigned(r[31:16]) % 3);
        ch_dest[c] = r[14:13];
        have_beat[c] = 1'b1;
        gen_cnt[c]++;
    endtask

    //////////////////////////////////////////////////
    // monitor sampling on the rising edge

    always @(posedge clk)
    begin
        if (!started)
        begin
            assert (l2_req == 1'b0) else
            begin
                $display("[ERROR] %0t l2_req_o expected 0 got %b", $time, l2_req);
                error_cnt++;
            end
            assert (ch_ready == '0) else
            begin
                $display("[ERROR] %0t ch_ready_o expected 0 got %b", $time, ch_ready);
                error_cnt++;
            end
        end
        assert ($countones(ch_ready) <= 1) else
        begin
            $display("[ERROR] %0t ch_ready_o expected at most one bit got %b", $time, ch_ready);
            error_cnt++;
        end
        if (rstn)
        begin
            cycle_cnt++;
            if (prev_req && !prev_gnt)  // pending request must hold
            begin
                assert (l2_req == 1'b1) else
                begin
                    $display("[ERROR] %0t l2_req_o expected %b got %b", $time, 1'b1, l2_req);
                    error_cnt++;
                end
                assert (l2_addr == prev_addr) else
                begin
                    $display("[ERROR] %0t l2_addr_o expected %h got %h", $time, prev_addr,
                             l2_addr);
                    error_cnt++;
                end
                assert (l2_be == prev_be) else
                begin
                    $display("[ERROR] %0t l2_be_o expected %b got %b", $time, prev_be, l2_be);
                    error_cnt++;
                end
                assert (l2_wdata == prev_data) else
                begin
                    $display("[ERROR] %0t l2_wdata_o expected %h got %h", $time, prev_data,
                             l2_wdata);
                    error_cnt++;
                end
            end
            assert (!expect_second || l2_req) else
            begin
                $display("second write of a split beat not requested after the first grant");
                error_cnt++;
            end
            expect_second = 1'b0;
            if (l2_req && l2_gnt)
                check_write();
            for (int c = 0; c < N_CH; c++)
            begin
                if (ch_valid[c] && ch_ready[c])
                begin
                    push_expected(c, ch_addr[c], ch_size[c], ch_dest[c], ch_data[c]);
                    accept_cnt[c]++;
                end
            end
            prev_req  = l2_req;
            prev_gnt  = l2_gnt;
            prev_addr = l2_addr;
            prev_be   = l2_be;
            prev_data = l2_wdata;
        end
    end

    //////////////////////////////////////////////////
    // stimulus driven 1 ns after the rising edge

    always @(posedge clk)
    begin : drive
        ch_mask_t taken;
        int       r;
        taken = ch_valid & ch_ready;
        #1;
        if (started)
        begin
            for (int c = 0; c < N_CH; c++)
            begin
                if (taken[c])
                begin
                    have_beat[c] = 1'b0;
                    ch_valid[c]  = 1'b0;
                end
                if (!have_beat[c] && gen_cnt[c] < N_BEATS)
                    new_beat(c);
                if (have_beat[c] && !ch_valid[c])
                begin
                    r           = $random(seed);
                    ch_valid[c] = (gen_cnt[c] <= N_BURST) || (r[1:0] != 2'b00);
                end
            end
            r      = $random(seed);
            l2_gnt = r[0];  // about half the cycles
        end
    end

    initial
    begin
        ch_valid      = '0;
        ch_data       = '0;
        ch_addr       = '0;
        ch_size       = '0;
        ch_dest       = '0;
        l2_gnt        = 1'b0;
        started       = 1'b0;
        error_cnt     = 0;
        cycle_cnt     = 0;
        write_cnt     = 0;
        prev_req      = 1'b0;
        prev_gnt      = 1'b0;
        prev_addr     = '0;
        prev_be       = '0;
        prev_data     = '0;
        expect_second = 1'b0;
        for (int c = 0; c < N_CH; c++)
        begin
            accept_cnt[c] = 0;
            gen_cnt[c]    = 0;
            have_beat[c]  = 1'b0;
        end

        @(posedge rstn);
        repeat (2) @(posedge clk);  // idle cycles after reset
        #10 started = 1'b1;

        @(negedge clk);
        while (!all_done() && cycle_cnt < MAX_CYCLES)
            @(negedge clk);

        assert (all_done()) else
        begin
            $display("timeout after %0d cycles, %0d writes still pending", cycle_cnt,
                     exp_q.size());
            error_cnt++;
        end
        for (int c = 0; c < N_CH; c++)
        begin
            assert (accept_cnt[c] == N_BEATS) else
            begin
                $display("[ERROR] %0t accept_cnt[%0d] expected %0d got %0d", $time, c,
                         N_BEATS, accept_cnt[c]);
                error_cnt++;
            end
        end

        $display("errors %0d, beats %0d, writes %0d, cycles %0d", error_cnt, N_TOTAL,
                 write_cnt, cycle_cnt);
        if (error_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
//////////////////////////////////////////////////
// testbench clock and active low reset
// reset is released 1 ns after the last reset edge
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen
#(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 2
)
(
    output logic clk_o,
    output logic rstn_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial
    begin
        rstn_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rstn_o = 1'b1;
    end

endmodule

//--- udma_rx_top.sv
//////////////////////////////////////////////////
// udma receive path, arbiter then fifo then l2 writer
// channel and l2 sides are plain valid/ready and req/gnt
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rx_consts.svh"

module udma_rx_top
    import rx_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rstn_i,

    // receive channels
    input  ch_mask_t                       ch_valid_i,
    input  ch_data_t  [`RX_N_CHANNELS-1:0] ch_data_i,
    input  ch_addr_t  [`RX_N_CHANNELS-1:0] ch_addr_i,
    input  datasize_t [`RX_N_CHANNELS-1:0] ch_size_i,
    input  dest_t     [`RX_N_CHANNELS-1:0] ch_dest_i,
    output ch_mask_t                       ch_ready_o,

    // l2 write port
    output logic                           l2_req_o,
    input  logic                           l2_gnt_i,
    output l2_addr_t                       l2_addr_o,
    output byte_en_t                       l2_be_o,
    output ch_data_t                       l2_wdata_o
);

    rx_beat_if cap_if ();  // capture register to fifo
    rx_beat_if req_if ();  // fifo head to formatter

    rx_channel_arbiter rx_channel_arbiter_i
    (
        .clk_i      ( clk_i      ),
        .rstn_i     ( rstn_i     ),
        .ch_valid_i ( ch_valid_i ),
        .ch_data_i  ( ch_data_i  ),
        .ch_addr_i  ( ch_addr_i  ),
        .ch_size_i  ( ch_size_i  ),
        .ch_dest_i  ( ch_dest_i  ),
        .ch_ready_o ( ch_ready_o ),
        .cap_if     ( cap_if     )
    );

    rx_beat_fifo #(
        .DEPTH ( `RX_FIFO_DEPTH )
    ) rx_beat_fifo_i
    (
        .clk_i  ( clk_i  ),
        .rstn_i ( rstn_i ),
        .in_if  ( cap_if ),
        .out_if ( req_if )
    );

    l2_write_formatter l2_write_formatter_i
    (
        .clk_i      ( clk_i      ),
        .rstn_i     ( rstn_i     ),
        .req_if     ( req_if     ),
        .l2_req_o   ( l2_req_o   ),
        .l2_gnt_i   ( l2_gnt_i   ),
        .l2_addr_o  ( l2_addr_o  ),
        .l2_be_o    ( l2_be_o    ),
        .l2_wdata_o ( l2_wdata_o )
    );

endmodule

//--- l2_write_formatter.sv
//////////////////////////////////////////////////
// turns the fifo head beat into one or two l2 writes
// lanes outside the byte enables carry zeros
// size code 3 gives a write with no byte enabled
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rx_consts.svh"

module l2_write_formatter
    import rx_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,

    rx_beat_if.sink  req_if,

    output logic     l2_req_o,
    input  logic     l2_gnt_i,
    output l2_addr_t l2_addr_o,
    output byte_en_t l2_be_o,
    output ch_data_t l2_wdata_o
);

    localparam int BE_W   = $bits(byte_en_t);
    localparam int DATA_W = $bits(ch_data_t);
    localparam int WORD_W = `RX_ADDR_W - 2;

    split_state_t          r_state;
    split_state_t          s_state_next;

    logic [1:0]            s_offset;
    logic                  s_second;
    logic                  s_non_aligned;
    byte_en_t              s_size_mask;
    ch_data_t              s_beat_data;
    logic [2*BE_W-1:0]     s_lane_mask;  // high half goes to the next word
    logic [2*DATA_W-1:0]   s_lane_data;
    logic [WORD_W-1:0]     s_word_addr;

    assign s_offset = req_if.addr[1:0];
    assign s_second = (r_state == SPLIT_SECOND);

    //////////////////////////////////////////////////
    // size decode and lane placement

    always_comb
    begin
        case (req_if.size)
            2'd0:    s_size_mask = 4'b0001;
            2'd1:    s_size_mask = 4'b0011;
            2'd2:    s_size_mask = 4'b1111;
            default: s_size_mask = 4'b0000;
        endcase
    end

    // keep only the bytes the beat really carries
    always_comb
    begin
        for (int b = 0; b < BE_W; b++)
            s_beat_data[8*b +: 8] = s_size_mask[b] ? req_if.data[8*b +: 8] : 8'h00;
    end

    assign s_non_aligned = ((req_if.size == 2'd1) && (s_offset == 2'd3)) ||
                           ((req_if.size == 2'd2) && (s_offset != 2'd0));

    assign s_lane_mask = {{BE_W{1'b0}}, s_size_mask} << s_offset;
    assign s_lane_data = {{DATA_W{1'b0}}, s_beat_data} << {s_offset, 3'b000};

    assign l2_be_o    = s_second ? s_lane_mask[2*BE_W-1:BE_W] : s_lane_mask[BE_W-1:0];
    assign l2_wdata_o = s_second ? s_lane_data[2*DATA_W-1:DATA_W] : s_lane_data[DATA_W-1:0];

    //////////////////////////////////////////////////
    // address and region mapping

    assign s_word_addr = req_if.addr[`RX_ADDR_W-1:2] + {{(WORD_W-1){1'b0}}, s_second};

    always_comb
    begin
        l2_addr_o                 = '0;
        l2_addr_o[`RX_ADDR_W-1:0] = {s_word_addr, 2'b00};
        case (req_if.dest)
            2'd0:    l2_addr_o[31:24] = `RX_REGION_L2;
            2'd1:    l2_addr_o[31:20] = `RX_REGION_PERIPH;
            2'd2:    l2_addr_o[31:24] = `RX_REGION_L1;
            default: l2_addr_o[31:24] = `RX_REGION_ACCEL;
        endcase
    end

    //////////////////////////////////////////////////
    // split control

    assign l2_req_o = req_if.valid;

    // pop only on the grant of the last write
    assign req_if.ready = req_if.valid && l2_gnt_i && (s_second || !s_non_aligned);

    always_comb
    begin
        s_state_next = r_state;
        case (r_state)
            SPLIT_IDLE:
            begin
                if (req_if.valid && s_non_aligned && l2_gnt_i)
                    s_state_next = SPLIT_SECOND;
            end
            SPLIT_SECOND:
            begin
                if (l2_gnt_i)
                    s_state_next = SPLIT_IDLE;
            end
            default: s_state_next = SPLIT_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_state <= SPLIT_IDLE;
        else
            r_state <= s_state_next;
    end

endmodule

//--- rx_beat_fifo.sv
//////////////////////////////////////////////////
// request fifo between capture and l2 write stage
// no bypass, a pushed beat shows on the next cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rx_consts.svh"

module rx_beat_fifo
    import rx_pkg::*;
#(
    parameter int DEPTH = `RX_FIFO_DEPTH
)
(
    input  logic      clk_i,
    input  logic      rstn_i,
    rx_beat_if.sink   in_if,
    rx_beat_if.source out_if
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ch_data_t   mem_data [DEPTH];
    ch_addr_t   mem_addr [DEPTH];
    datasize_t  mem_size [DEPTH];
    dest_t      mem_dest [DEPTH];

    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;
    logic             s_push;
    logic             s_pop;

    assign in_if.ready  = (r_count != CNT_W'(DEPTH));
    assign out_if.valid = (r_count != '0);

    assign s_push = in_if.valid && in_if.ready;
    assign s_pop  = out_if.valid && out_if.ready;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end
        else
        begin
            if (s_push)
                r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            if (s_pop)
                r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            case ({s_push, s_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;  // both or none
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (s_push)
        begin
            mem_data[r_wr_ptr] <= in_if.data;
            mem_addr[r_wr_ptr] <= in_if.addr;
            mem_size[r_wr_ptr] <= in_if.size;
            mem_dest[r_wr_ptr] <= in_if.dest;
        end
    end

    assign out_if.data = mem_data[r_rd_ptr];
    assign out_if.addr = mem_addr[r_rd_ptr];
    assign out_if.size = mem_size[r_rd_ptr];
    assign out_if.dest = mem_dest[r_rd_ptr];

endmodule

//--- rx_channel_arbiter.sv
//////////////////////////////////////////////////
// round robin over the receive channels
// one beat per cycle into a single capture register
// at most one ch_ready_o bit is high per cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rx_consts.svh"

module rx_channel_arbiter
    import rx_pkg::*;
(
    input  logic                                  clk_i,
    input  logic                                  rstn_i,

    input  ch_mask_t                              ch_valid_i,
    input  ch_data_t  [`RX_N_CHANNELS-1:0]        ch_data_i,
    input  ch_addr_t  [`RX_N_CHANNELS-1:0]        ch_addr_i,
    input  datasize_t [`RX_N_CHANNELS-1:0]        ch_size_i,
    input  dest_t     [`RX_N_CHANNELS-1:0]        ch_dest_i,
    output ch_mask_t                              ch_ready_o,

    rx_beat_if.source                             cap_if
);

    localparam int N        = `RX_N_CHANNELS;
    localparam int CH_IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [CH_IDX_W-1:0] r_ptr;     // last granted channel
    logic [CH_IDX_W-1:0] s_gnt_idx;
    logic                s_found;
    logic                s_take;
    logic                s_accept;

    logic                r_valid;
    ch_data_t            r_data;
    ch_addr_t            r_addr;
    datasize_t           r_size;
    dest_t               r_dest;

    //////////////////////////////////////////////////
    // channel selection

    // first valid channel after the last grant
    always_comb
    begin : rr_pick
        int cand;
        s_found   = 1'b0;
        s_gnt_idx = r_ptr;
        for (int i = 1; i <= N; i++)
        begin
            cand = (int'(r_ptr) + i) % N;
            if (!s_found && ch_valid_i[cand])
            begin
                s_found   = 1'b1;
                s_gnt_idx = CH_IDX_W'(cand);
            end
        end
    end

    assign s_take   = !r_valid || cap_if.ready;  // register empty or emptying now
    assign s_accept = s_take && s_found;

    always_comb
    begin
        ch_ready_o            = '0;
        ch_ready_o[s_gnt_idx] = s_accept;
    end

    //////////////////////////////////////////////////
    // capture register

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_valid <= 1'b0;
            r_ptr   <= CH_IDX_W'(N - 1);  // channel 0 first after reset
        end
        else
        begin
            if (s_accept)
            begin
                r_valid <= 1'b1;
                r_ptr   <= s_gnt_idx;
            end
            else if (cap_if.ready)
            begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (s_accept)
        begin
            r_data <= ch_data_i[s_gnt_idx];
            r_addr <= ch_addr_i[s_gnt_idx];
            r_size <= ch_size_i[s_gnt_idx];
            r_dest <= ch_dest_i[s_gnt_idx];
        end
    end

    assign cap_if.valid = r_valid;
    assign cap_if.data  = r_data;
    assign cap_if.addr  = r_addr;
    assign cap_if.size  = r_size;
    assign cap_if.dest  = r_dest;

endmodule

//--- rx_beat_if.sv
//////////////////////////////////////////////////
// one receive beat between pipeline stages
// transfer on valid and ready, beat held while stalled
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface rx_beat_if
    import rx_pkg::*;
();

    logic      valid;
    logic      ready;
    ch_data_t  data;
    ch_addr_t  addr;
    datasize_t size;
    dest_t     dest;

    modport source
    (
        output valid, data, addr, size, dest,
        input  ready
    );

    modport sink
    (
        input  valid, data, addr, size, dest,
        output ready
    );

endinterface

//--- rx_pkg.sv
//////////////////////////////////////////////////
// types of the udma receive path
// sizes follow rx_consts.svh
//////////////////////////////////////////////////

`include "rx_consts.svh"

package rx_pkg;

    // channel side
    typedef logic [`RX_ADDR_W-1:0]     ch_addr_t;  // byte address
    typedef logic [`RX_DATA_W-1:0]     ch_data_t;  // right justified
    typedef logic [1:0]                datasize_t; // 0 byte, 1 half, 2 word
    typedef logic [1:0]                dest_t;
    typedef logic [`RX_N_CHANNELS-1:0] ch_mask_t;

    // l2 side
    typedef logic [`RX_L2_ADDR_W-1:0]  l2_addr_t;
    typedef logic [`RX_DATA_W/8-1:0]   byte_en_t;

    //////////////////////////////////////////////////
    // formatter state, second write only for split beats

    typedef enum logic
    {
        SPLIT_IDLE,
        SPLIT_SECOND
    } split_state_t;

endpackage

//--- rx_consts.svh
//////////////////////////////////////////////////
// receive path constants shared by RTL and testbench
// channel count and fifo depth are free, the bus stays 32 bit
// region prefixes are sized literals, their width sets the field
//////////////////////////////////////////////////

`ifndef RX_CONSTS_SVH
`define RX_CONSTS_SVH

// pipeline sizing
`define RX_N_CHANNELS 4
`define RX_FIFO_DEPTH 4

// widths
`define RX_ADDR_W    16
`define RX_DATA_W    32
`define RX_L2_ADDR_W 32

//////////////////////////////////////////////////
// high address prefix per destination code

`define RX_REGION_L2     8'h1C   // code 0, bits 31:24
`define RX_REGION_PERIPH 12'h1A1 // code 1, bits 31:20
`define RX_REGION_L1     8'h10   // code 2, bits 31:24
`define RX_REGION_ACCEL  8'h1E   // code 3, bits 31:24

`endif
